// ==== Bender.yml ====
package:
  name: axis_pkt

sources:
  - include_dirs:
      - logic
    files:
      - logic/axis_pkt_pkg.sv
      - logic/axis_if.sv
      - logic/axis_frame_trunc.sv
      - logic/axis_async_fifo.sv
      - logic/axis_frame_stats.sv
      - logic/axis_pkt_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/tb_axis_pkt_top.sv

// ==== logic/axis_async_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_pkt_cfg.svh"

module axis_async_fifo (
  input  logic   input_clk,
  input  logic   output_clk,
  input  logic   output_rst_sync3,
  output logic   input_rst,
  axis_if.sink   wr,
  axis_if.source rd
);
  import axis_pkt_pkg::*;

  localparam int AW     = `AXIS_FIFO_ADDR_WIDTH;
  localparam int DEPTH  = 2 ** AW;
  localparam int WORD_W = `AXIS_DATA_WIDTH + 2;

  typedef logic [AW:0] ptr_t;

  // reset bridge into the write domain, starts asserted
  logic input_rst_sync1 = 1'b1;
  logic input_rst_sync2 = 1'b1;
  logic input_rst_sync3 = 1'b1;

  ptr_t wr_ptr;
  ptr_t wr_ptr_next;
  ptr_t wr_ptr_gray;
  ptr_t rd_ptr;
  ptr_t rd_ptr_next;
  ptr_t rd_ptr_gray;
  ptr_t wr_ptr_gray_sync1;
  ptr_t wr_ptr_gray_sync2;
  ptr_t rd_ptr_gray_sync1;
  ptr_t rd_ptr_gray_sync2;
  ptr_t wr_used;

  logic [WORD_W-1:0] mem [DEPTH];

  data_t out_tdata;
  logic  out_tlast;
  logic  out_tuser;
  logic  out_valid;

  logic full;
  logic empty;
  logic write;
  logic read;

  function automatic ptr_t gray2bin(input ptr_t g);
    ptr_t b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  always_ff @(posedge input_clk) begin
    input_rst_sync1 <= output_rst_sync3;
    input_rst_sync2 <= input_rst_sync1;
    input_rst_sync3 <= input_rst_sync2;
  end

  assign input_rst = input_rst_sync3;

  // full when the two top gray bits differ and the rest match
  assign full = (wr_ptr_gray[AW] != rd_ptr_gray_sync2[AW]) &&
                (wr_ptr_gray[AW-1] != rd_ptr_gray_sync2[AW-1]) &&
                (wr_ptr_gray[AW-2:0] == rd_ptr_gray_sync2[AW-2:0]);
  assign empty = (rd_ptr_gray == wr_ptr_gray_sync2);

  assign wr.tready = !full && !input_rst_sync3;
  assign write     = wr.tvalid && wr.tready;

  // refill the output register when it is empty or being drained
  assign read = (rd.tready || !out_valid) && !empty;

  assign wr_ptr_next = wr_ptr + ptr_t'(1);
  assign rd_ptr_next = rd_ptr + ptr_t'(1);

  always_ff @(posedge input_clk) begin
    if (write) begin
      mem[wr_ptr[AW-1:0]] <= {wr.tlast, wr.tuser, wr.tdata};
    end
  end

  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else if (write) begin
      wr_ptr      <= wr_ptr_next;
      wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
    end
  end

  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      rd_ptr_gray_sync1 <= '0;
      rd_ptr_gray_sync2 <= '0;
    end else begin
      rd_ptr_gray_sync1 <= rd_ptr_gray;
      rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else if (read) begin
      rd_ptr      <= rd_ptr_next;
      rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      wr_ptr_gray_sync1 <= '0;
      wr_ptr_gray_sync2 <= '0;
    end else begin
      wr_ptr_gray_sync1 <= wr_ptr_gray;
      wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
    end
  end

  always_ff @(posedge output_clk) begin
    if (read) begin
      {out_tlast, out_tuser, out_tdata} <= mem[rd_ptr[AW-1:0]];
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      out_valid <= 1'b0;
    end else if (rd.tready || !out_valid) begin
      out_valid <= !empty;
    end
  end

  assign rd.tdata  = out_tdata;
  assign rd.tlast  = out_tlast;
  assign rd.tuser  = out_tuser;
  assign rd.tvalid = out_valid;

  // occupancy seen from the write side, read pointer lags so this is conservative
  assign wr_used = wr_ptr - gray2bin(rd_ptr_gray_sync2);

  a_no_write_full: assert property (
    @(posedge input_clk) disable iff (input_rst_sync3)
    write |-> (wr_used < DEPTH)
  );

  a_out_stable: assert property (
    @(posedge output_clk) disable iff (output_rst_sync3)
    (rd.tvalid && !rd.tready) |=>
      (rd.tvalid && $stable(rd.tdata) && $stable(rd.tlast) && $stable(rd.tuser))
  );

endmodule

`default_nettype wire

// ==== logic/axis_frame_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_pkt_cfg.svh"

module axis_frame_stats (
  input  logic                      output_clk,
  input  logic                      output_rst_sync3,
  axis_if.monitor                   mon,
  output axis_pkt_pkg::stat_count_t frame_count,
  output axis_pkt_pkg::stat_count_t error_count,
  output axis_pkt_pkg::stat_count_t byte_count,
  output logic                      stats_valid
);
  import axis_pkt_pkg::*;

  localparam stat_count_t BYTES_PER_BEAT = stat_count_t'(`AXIS_DATA_WIDTH / 8);

  // running total, published to byte_count only at frame ends
  stat_count_t byte_run;
  logic        xfer;
  logic        frame_end;

  assign xfer      = mon.tvalid && mon.tready;
  assign frame_end = xfer && mon.tlast;

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      frame_count <= '0;
      error_count <= '0;
      byte_count  <= '0;
      byte_run    <= '0;
      stats_valid <= 1'b0;
    end else begin
      stats_valid <= frame_end;
      if (xfer) begin
        byte_run <= byte_run + BYTES_PER_BEAT;
      end
      if (frame_end) begin
        frame_count <= frame_count + stat_count_t'(1);
        byte_count  <= byte_run + BYTES_PER_BEAT;
        if (mon.tuser) begin
          error_count <= error_count + stat_count_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/axis_frame_trunc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_pkt_cfg.svh"

module axis_frame_trunc (
  input  logic   input_clk,
  input  logic   input_rst,
  axis_if.sink   in,
  axis_if.source out
);
  import axis_pkt_pkg::*;

  localparam beat_count_t LAST_BEAT = beat_count_t'(`AXIS_MAX_FRAME_LEN - 1);

  trunc_state_e state;
  beat_count_t  beat_cnt;
  logic         at_limit;
  logic         cut;
  logic         accept;

  assign at_limit = (beat_cnt == LAST_BEAT);

  // frame still open on its last allowed beat
  assign cut = at_limit && !in.tlast;

  assign out.tdata  = in.tdata;
  assign out.tvalid = in.tvalid && (state == TRUNC_PASS);
  assign out.tlast  = in.tlast || cut;
  assign out.tuser  = in.tuser || cut;

  // tail of a cut frame is swallowed without waiting on the fifo
  assign in.tready = (state == TRUNC_DROP) ? 1'b1 : out.tready;

  assign accept = in.tvalid && in.tready;

  always_ff @(posedge input_clk) begin
    if (input_rst) begin
      state    <= TRUNC_PASS;
      beat_cnt <= '0;
    end else if (accept) begin
      case (state)
        TRUNC_PASS: begin
          if (in.tlast || at_limit) begin
            beat_cnt <= '0;
          end else begin
            beat_cnt <= beat_cnt + beat_count_t'(1);
          end
          if (cut) begin
            state <= TRUNC_DROP;
          end
        end
        TRUNC_DROP: begin
          if (in.tlast) begin
            state <= TRUNC_PASS;
          end
        end
        default: begin
          state <= TRUNC_PASS;
        end
      endcase
    end
  end

  // a beat stalled by the fifo keeps its flags, cut marking included
  a_out_stable: assert property (
    @(posedge input_clk) disable iff (input_rst)
    (out.tvalid && !out.tready) |=>
      (out.tvalid && $stable(out.tdata) && $stable(out.tlast) && $stable(out.tuser))
  );

endmodule

`default_nettype wire

// ==== logic/axis_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface axis_if;
  import axis_pkt_pkg::*;

  data_t tdata;
  logic  tvalid;
  logic  tready;
  logic  tlast;
  logic  tuser;

  modport source (
    output tdata,
    output tvalid,
    input  tready,
    output tlast,
    output tuser
  );

  modport sink (
    input  tdata,
    input  tvalid,
    output tready,
    input  tlast,
    input  tuser
  );

  modport monitor (
    input tdata,
    input tvalid,
    input tready,
    input tlast,
    input tuser
  );

endinterface

`default_nettype wire

// ==== logic/axis_pkt_cfg.svh ====
`ifndef AXIS_PKT_CFG_SVH
`define AXIS_PKT_CFG_SVH

// stream payload width in bits
`define AXIS_DATA_WIDTH 8

// log2 of fifo depth
`define AXIS_FIFO_ADDR_WIDTH 4

// beats allowed per frame before the truncator cuts it
`define AXIS_MAX_FRAME_LEN 12

// width of each statistics counter
`define AXIS_CNT_WIDTH 16

`endif

// ==== logic/axis_pkt_pkg.sv ====
`default_nettype none

`include "axis_pkt_cfg.svh"

package axis_pkt_pkg;

  typedef logic [`AXIS_DATA_WIDTH-1:0] data_t;

  typedef logic [`AXIS_CNT_WIDTH-1:0] stat_count_t;

  // must hold the value AXIS_MAX_FRAME_LEN itself
  typedef logic [$clog2(`AXIS_MAX_FRAME_LEN + 1)-1:0] beat_count_t;

  typedef enum logic {
    TRUNC_PASS,
    TRUNC_DROP
  } trunc_state_e;

endpackage

`default_nettype wire

// ==== logic/axis_pkt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_pkt_top (
  input  logic                      input_clk,
  input  logic                      output_clk,
  input  logic                      output_rst_sync3,

  input  axis_pkt_pkg::data_t       s_tdata,
  input  logic                      s_tvalid,
  output logic                      s_tready,
  input  logic                      s_tlast,
  input  logic                      s_tuser,

  output axis_pkt_pkg::data_t       m_tdata,
  output logic                      m_tvalid,
  input  logic                      m_tready,
  output logic                      m_tlast,
  output logic                      m_tuser,

  output axis_pkt_pkg::stat_count_t frame_count,
  output axis_pkt_pkg::stat_count_t error_count,
  output axis_pkt_pkg::stat_count_t byte_count,
  output logic                      stats_valid
);

  logic input_rst;

  // input side bundle for the plain s_* ports
  axis_if trunc_in ();
  axis_if trunc_to_fifo ();
  axis_if fifo_out ();

  assign trunc_in.tdata  = s_tdata;
  assign trunc_in.tvalid = s_tvalid;
  assign trunc_in.tlast  = s_tlast;
  assign trunc_in.tuser  = s_tuser;
  assign s_tready        = trunc_in.tready;

  assign m_tdata         = fifo_out.tdata;
  assign m_tvalid        = fifo_out.tvalid;
  assign m_tlast         = fifo_out.tlast;
  assign m_tuser         = fifo_out.tuser;
  assign fifo_out.tready = m_tready;

  axis_frame_trunc u_trunc (
    .input_clk (input_clk),
    .input_rst (input_rst),
    .in        (trunc_in),
    .out       (trunc_to_fifo)
  );

  axis_async_fifo u_fifo (
    .input_clk        (input_clk),
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .input_rst        (input_rst),
    .wr               (trunc_to_fifo),
    .rd               (fifo_out)
  );

  axis_frame_stats u_stats (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .mon              (fifo_out),
    .frame_count      (frame_count),
    .error_count      (error_count),
    .byte_count       (byte_count),
    .stats_valid      (stats_valid)
  );

endmodule

`default_nettype wire

// ==== sim/tb_axis_pkt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_pkt_cfg.svh"

module tb_axis_pkt_top;
  import axis_pkt_pkg::*;

  localparam int OUT_PERIOD = 20;
  localparam int IN_PERIOD  = 14;
  localparam int MAX_LEN    = `AXIS_MAX_FRAME_LEN;
  localparam int BYTES_PER_BEAT = `AXIS_DATA_WIDTH / 8;

  logic        input_clk = 1'b0;
  logic        output_clk = 1'b0;
  logic        output_rst_sync3;
  data_t       s_tdata;
  logic        s_tvalid;
  logic        s_tready;
  logic        s_tlast;
  logic        s_tuser;
  data_t       m_tdata;
  logic        m_tvalid;
  logic        m_tready;
  logic        m_tlast;
  logic        m_tuser;
  stat_count_t frame_count;
  stat_count_t error_count;
  stat_count_t byte_count;
  logic        stats_valid;

  // frame table, one entry per frame
  int tbl_len [$];
  bit tbl_err [$];
  int tbl_gap [$];
  bit tbl_rand [$];

  // expected beats in arrival order
  data_t exp_data_q [$];
  logic  exp_last_q [$];
  logic  exp_user_q [$];

  logic [31:0] data_lfsr = 32'hd384_c1b2;
  logic [31:0] ready_lfsr = 32'hd384_c1b2;

  stat_count_t rx_frames = '0;
  stat_count_t rx_errors = '0;
  stat_count_t rx_bytes = '0;
  data_t       e_data;
  logic        e_last;
  logic        e_user;

  int value_errors = 0;
  int other_errors = 0;
  int beats_seen = 0;
  int stats_seen = 0;
  int exp_frames = 0;
  int total_beats = 0;
  bit table_ready = 1'b0;
  bit ready_random = 1'b0;
  bit saw_stall = 1'b0;

  axis_pkt_top u_dut (
    .input_clk        (input_clk),
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .s_tdata          (s_tdata),
    .s_tvalid         (s_tvalid),
    .s_tready         (s_tready),
    .s_tlast          (s_tlast),
    .s_tuser          (s_tuser),
    .m_tdata          (m_tdata),
    .m_tvalid         (m_tvalid),
    .m_tready         (m_tready),
    .m_tlast          (m_tlast),
    .m_tuser          (m_tuser),
    .frame_count      (frame_count),
    .error_count      (error_count),
    .byte_count       (byte_count),
    .stats_valid      (stats_valid)
  );

  always #(OUT_PERIOD / 2) output_clk = ~output_clk;
  always #(IN_PERIOD / 2.0) input_clk = ~input_clk;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic data_t rand_byte();
    data_t v;
    for (int b = 0; b < $bits(data_t); b++) begin
      data_lfsr = lfsr_step(data_lfsr);
      v[b] = data_lfsr[0];
    end
    return v;
  endfunction

  function automatic logic rand_ready();
    ready_lfsr = lfsr_step(ready_lfsr);
    return ready_lfsr[0];
  endfunction

  task automatic add_frame(input int len, input bit err, input int gap, input bit rnd);
    tbl_len.push_back(len);
    tbl_err.push_back(err);
    tbl_gap.push_back(gap);
    tbl_rand.push_back(rnd);
    total_beats += len;
  endtask

  task automatic load_table();
    add_frame(5, 0, 0, 0);
    add_frame(MAX_LEN, 0, 3, 0);
    add_frame(3, 1, 1, 0);
    // oversize, then a short frame that must pass untouched
    add_frame(MAX_LEN + 8, 0, 0, 0);
    add_frame(4, 0, 2, 0);
    add_frame(1, 0, 0, 1);
    add_frame(MAX_LEN + 4, 1, 0, 1);
    add_frame(10, 0, 0, 1);
    add_frame(MAX_LEN, 0, 0, 1);
    add_frame(8, 1, 0, 1);
    add_frame(30, 0, 0, 1);
    add_frame(6, 1, 4, 1);
    table_ready = 1'b1;
  endtask

  task automatic check_beat(input data_t got_d, input data_t exp_d, input logic got_l,
                            input logic exp_l, input logic got_u, input logic exp_u);
    if (got_d !== exp_d) begin
      value_errors++;
      $display("[ERROR] %0t m_tdata got %02h expected %02h", $time, got_d, exp_d);
    end
    if (got_l !== exp_l) begin
      value_errors++;
      $display("[ERROR] %0t m_tlast got %b expected %b", $time, got_l, exp_l);
    end
    if (got_u !== exp_u) begin
      value_errors++;
      $display("[ERROR] %0t m_tuser got %b expected %b", $time, got_u, exp_u);
    end
  endtask

  task automatic check_count(input string name, input stat_count_t got, input stat_count_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic send_beat(input data_t d, input logic last, input logic user);
    s_tdata  = d;
    s_tvalid = 1'b1;
    s_tlast  = last;
    s_tuser  = user;
    do begin
      @(posedge input_clk);
    end while (!s_tready);
    #2;
    s_tvalid = 1'b0;
  endtask

  // model applies the truncation rule before the beat goes out
  task automatic apply_frame(input int f);
    int   len;
    data_t d;
    logic last;
    logic user;
    logic cut;
    len = tbl_len[f];
    ready_random = tbl_rand[f];
    exp_frames++;
    for (int i = 0; i < len; i++) begin
      d = rand_byte();
      last = (i == len - 1);
      user = tbl_err[f] && last;
      if (i < MAX_LEN) begin
        cut = (i == MAX_LEN - 1) && !last;
        exp_data_q.push_back(d);
        exp_last_q.push_back(last || cut);
        exp_user_q.push_back(user || cut);
      end
      send_beat(d, last, user);
    end
    if (tbl_gap[f] > 0) begin
      repeat (tbl_gap[f]) @(posedge input_clk);
      #2;
    end
  endtask

  task automatic report_and_finish();
    $display("checked %0d beats and %0d stats updates, %0d value errors, %0d other errors",
             beats_seen, stats_seen, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  always @(posedge output_clk) begin
    #2;
    m_tready = ready_random ? rand_ready() : 1'b1;
  end

  always @(posedge input_clk) begin
    if (ready_random && s_tvalid && !s_tready) begin
      saw_stall = 1'b1;
    end
  end

  // stats check uses totals up to the previous edge, then this edge's beat is taken
  always @(posedge output_clk) begin
    if (!output_rst_sync3) begin
      if (stats_valid) begin
        check_count("frame_count", frame_count, rx_frames);
        check_count("error_count", error_count, rx_errors);
        check_count("byte_count", byte_count, rx_bytes);
        stats_seen++;
      end
      if (m_tvalid && m_tready) begin
        if (exp_data_q.size() == 0) begin
          other_errors++;
          $display("at %0t a beat arrived that no sent frame accounts for", $time);
        end else begin
          e_data = exp_data_q.pop_front();
          e_last = exp_last_q.pop_front();
          e_user = exp_user_q.pop_front();
          check_beat(m_tdata, e_data, m_tlast, e_last, m_tuser, e_user);
          beats_seen++;
          rx_bytes = rx_bytes + stat_count_t'(BYTES_PER_BEAT);
          if (e_last) begin
            rx_frames = rx_frames + stat_count_t'(1);
            if (e_user) begin
              rx_errors = rx_errors + stat_count_t'(1);
            end
          end
        end
      end
    end
  end

  initial begin : watchdog
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(total_beats) * 4 * OUT_PERIOD + 2000;
    #(limit_ns);
    other_errors++;
    $display("timeout after %0d ns, %0d expected beats never arrived",
             limit_ns, exp_data_q.size());
    report_and_finish();
  end

  initial begin
    output_rst_sync3 = 1'b1;
    s_tdata  = '0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    s_tuser  = 1'b0;
    m_tready = 1'b1;
    load_table();
    repeat (5) @(posedge output_clk);
    #2;
    output_rst_sync3 = 1'b0;
    @(posedge output_clk);
    check_flag("m_tvalid", m_tvalid, 1'b0);
    check_flag("stats_valid", stats_valid, 1'b0);
    check_count("frame_count", frame_count, '0);
    check_count("error_count", error_count, '0);
    check_count("byte_count", byte_count, '0);
    @(posedge input_clk);
    #2;
    for (int f = 0; f < tbl_len.size(); f++) begin
      apply_frame(f);
    end
    while (exp_data_q.size() != 0 || stats_seen < exp_frames) begin
      @(posedge output_clk);
    end
    repeat (10) @(posedge output_clk);
    if (stats_seen != exp_frames) begin
      other_errors++;
      $display("saw %0d stats updates for %0d frames", stats_seen, exp_frames);
    end
    if (!saw_stall) begin
      other_errors++;
      $display("s_tready never dropped under random back-pressure, the FIFO never filled");
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/axis_pkt_pkg.sv
logic/axis_if.sv
logic/axis_frame_trunc.sv
logic/axis_async_fifo.sv
logic/axis_frame_stats.sv
logic/axis_pkt_top.sv
sim/tb_axis_pkt_top.sv
